//--- compile.f
+incdir+include
src/bus_pkg.sv
src/bus_strobe_sync.sv
src/memory_map_decoder.sv
src/io_register_bank.sv
src/video_ram.sv
src/read_data_mux.sv
src/bus_controller_top.sv
verification/tb_clock_gen.sv
verification/tb_bus_controller.sv

//--- include/bus_config.svh
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Bank register reset values {ro, overlay, page}
//////////////////////////////////////////////////////////////////////
`define BANK0_RESET        8'hC0    // Read-only overlay, page 0
`define BANK1_RESET        8'h21    // RAM page 33
`define BANK2_RESET        8'h22    // RAM page 34
`define BANK3_RESET        8'h13    // Page 19

//////////////////////////////////////////////////////////////////////
// IO ports, low address byte
//////////////////////////////////////////////////////////////////////
`define IO_BANK_BASE       8'hF0    // F0..F3
`define IO_CASSETTE        8'hFC
`define IO_VSYNC_CPM       8'hFD    // Read vsync, write CP/M remap
`define IO_PRINTER         8'hFE
`define IO_KEYB_SCRAMBLE   8'hFF    // Read keyboard, write scramble

// Overlay slots in address bits 13:11
`define VRAM_SLOT          3'd6     // 3000-37FF
`define SYSRAM_SLOT        3'd7     // 3800-3FFF
`define VRAM_ADDR_BITS     11

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the bus controller testbench with Verilator, from the project root

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_bus_controller -o tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "sim passed" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi

//--- src/bus_controller_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module bus_controller_top import bus_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  z80_bus_t    bus,
    input  logic [63:0] keys,
    input  logic        cassette_in,
    input  logic        printer_in,
    input  logic        vblank,
    output logic [7:0]  d_out,
    output logic        d_oe,
    output logic        rom_ce_n,
    output logic        ram_ce_n,
    output logic [4:0]  ba,
    output logic        cassette_out,
    output logic        printer_out,
    output logic        cpm_remap,
    output logic [7:0]  scramble_value
);

    bus_event_t  evt;
    mem_select_t sel;
    bank_file_t  banks;
    bank_reg_u   active_bank;
    logic        internal;

    logic [`VRAM_ADDR_BITS-1:0] vram_addr;
    logic [7:0]                 vram_data;
    logic                       vram_wren;

    //////////////////////////////////////////////////////////////////////
    // Strobe sync and decoding
    //////////////////////////////////////////////////////////////////////
    bus_strobe_sync u_sync (
        .sysclk (sysclk),
        .reset  (reset),
        .bus    (bus),
        .evt    (evt)
    );

    memory_map_decoder u_decoder (
        .bus         (bus),
        .banks       (banks),
        .sel         (sel),
        .active_bank (active_bank),
        .internal    (internal)
    );

    //////////////////////////////////////////////////////////////////////
    // Registers and VRAM
    //////////////////////////////////////////////////////////////////////
    io_register_bank u_regs (
        .sysclk         (sysclk),
        .reset          (reset),
        .evt            (evt),
        .sel            (sel),
        .banks          (banks),
        .cassette_out   (cassette_out),
        .printer_out    (printer_out),
        .cpm_remap      (cpm_remap),
        .scramble_value (scramble_value)
    );

    assign vram_addr = bus.a[`VRAM_ADDR_BITS-1:0];
    assign vram_wren = sel.vram && evt.wr_pulse;

    video_ram u_vram (
        .sysclk (sysclk),
        .addr   (vram_addr),
        .wrdata (evt.wr_data),
        .wren   (vram_wren),
        .rddata (vram_data)
    );

    // Read path and external enables
    read_data_mux u_mux (
        .sel         (sel),
        .active_bank (active_bank),
        .internal    (internal),
        .bus         (bus),
        .banks       (banks),
        .vram_data   (vram_data),
        .keys        (keys),
        .cassette_in (cassette_in),
        .printer_in  (printer_in),
        .vblank      (vblank),
        .d_out       (d_out),
        .d_oe        (d_oe),
        .rom_ce_n    (rom_ce_n),
        .ram_ce_n    (ram_ce_n),
        .ba          (ba)
    );

endmodule

`default_nettype wire

//--- src/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // CPU bus as seen by the board, strobes active low
    typedef struct packed {
        logic [15:0] a;
        logic [7:0]  d;
        logic        rd_n;
        logic        wr_n;
        logic        mreq_n;
        logic        iorq_n;
    } z80_bus_t;

    // Single-cycle bus events plus last written byte
    typedef struct packed {
        logic       rd_pulse;
        logic       wr_pulse;
        logic [7:0] wr_data;
    } bus_event_t;

    typedef struct packed {
        logic       ro;         // Block memory writes
        logic       overlay;    // VRAM and sysram overlay in the window
        logic [5:0] page;
    } bank_fields_t;

    typedef union packed {
        logic [7:0]   raw;
        bank_fields_t f;
    } bank_reg_u;

    typedef bank_reg_u [3:0] bank_file_t;

    typedef struct packed {
        logic       vram;
        logic       sysram;
        logic       rom;
        logic       ram;
        logic       io_bank;
        logic       io_cassette;
        logic       io_vsync_cpm;
        logic       io_printer;
        logic       io_keyb_scramble;
        logic [1:0] io_bank_index;
    } mem_select_t;

endpackage

`default_nettype wire

//--- src/bus_strobe_sync.sv
`timescale 1ns/1ps
`default_nettype none

module bus_strobe_sync import bus_pkg::*; (
    input  logic       sysclk,
    input  logic       reset,
    input  z80_bus_t   bus,
    output bus_event_t evt
);

    logic [2:0] rd_hist;    // Newest sample in bit 0
    logic [2:0] wr_hist;
    logic [7:0] wr_data;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rd_hist <= 3'b111;
            wr_hist <= 3'b111;
        end else begin
            rd_hist <= {rd_hist[1:0], bus.rd_n};
            wr_hist <= {wr_hist[1:0], bus.wr_n};
        end
    end

    // Data is stable while the CPU holds wr_n low
    always_ff @(posedge sysclk) begin
        if (!bus.wr_n)
            wr_data <= bus.d;
    end

    // Falling edge seen in the older two stages
    assign evt.rd_pulse = (rd_hist[2:1] == 2'b10);
    assign evt.wr_pulse = (wr_hist[2:1] == 2'b10);
    assign evt.wr_data  = wr_data;

    // One bus cycle is either a read or a write
    a_no_rd_wr_overlap: assert property (@(posedge sysclk) disable iff (reset)
        !(evt.rd_pulse && evt.wr_pulse));

endmodule

`default_nettype wire

//--- src/io_register_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module io_register_bank import bus_pkg::*; (
    input  logic        sysclk,
    input  logic        reset,
    input  bus_event_t  evt,
    input  mem_select_t sel,
    output bank_file_t  banks,
    output logic        cassette_out,
    output logic        printer_out,
    output logic        cpm_remap,
    output logic [7:0]  scramble_value
);

    logic wr_bank;
    logic wr_cassette;
    logic wr_cpm;
    logic wr_printer;
    logic wr_scramble;

    // Write strobes per target
    assign wr_bank     = evt.wr_pulse && sel.io_bank;
    assign wr_cassette = evt.wr_pulse && sel.io_cassette;
    assign wr_cpm      = evt.wr_pulse && sel.io_vsync_cpm;
    assign wr_printer  = evt.wr_pulse && sel.io_printer;
    assign wr_scramble = evt.wr_pulse && sel.io_keyb_scramble;

    //////////////////////////////////////////////////////////////////////
    // Bank registers F0..F3
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            banks[0].raw <= `BANK0_RESET;
            banks[1].raw <= `BANK1_RESET;
            banks[2].raw <= `BANK2_RESET;
            banks[3].raw <= `BANK3_RESET;
        end else if (wr_bank) begin
            banks[sel.io_bank_index].raw <= evt.wr_data;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output latches FC..FF
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            cassette_out   <= 1'b0;
            cpm_remap      <= 1'b0;
            printer_out    <= 1'b0;
            scramble_value <= 8'h00;
        end else begin
            if (wr_cassette)
                cassette_out <= evt.wr_data[0];
            if (wr_cpm)
                cpm_remap <= evt.wr_data[0];       // Shares FD with vsync read
            if (wr_printer)
                printer_out <= evt.wr_data[0];
            if (wr_scramble)
                scramble_value <= evt.wr_data;     // Full byte
        end
    end

endmodule

`default_nettype wire

//--- src/memory_map_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module memory_map_decoder import bus_pkg::*; (
    input  z80_bus_t    bus,
    input  bank_file_t  banks,
    output mem_select_t sel,
    output bank_reg_u   active_bank,
    output logic        internal
);

    logic mem_cycle;
    logic io_cycle;
    logic allow_mem;
    logic ro_write;

    //////////////////////////////////////////////////////////////////////
    // Bank selection from the 16 KB window
    //////////////////////////////////////////////////////////////////////
    assign active_bank = banks[bus.a[15:14]];

    assign mem_cycle = !bus.mreq_n;
    assign io_cycle  = !bus.iorq_n;

    //////////////////////////////////////////////////////////////////////
    // Overlay and IO decoding
    //////////////////////////////////////////////////////////////////////
    assign sel.vram   = mem_cycle && active_bank.f.overlay
                        && (bus.a[13:11] == `VRAM_SLOT);
    assign sel.sysram = mem_cycle && active_bank.f.overlay
                        && (bus.a[13:11] == `SYSRAM_SLOT);

    // Four bank ports share the upper six address bits
    assign sel.io_bank          = io_cycle && ({bus.a[7:2], 2'b00} == `IO_BANK_BASE);
    assign sel.io_bank_index    = bus.a[1:0];
    assign sel.io_cassette      = io_cycle && (bus.a[7:0] == `IO_CASSETTE);
    assign sel.io_vsync_cpm     = io_cycle && (bus.a[7:0] == `IO_VSYNC_CPM);
    assign sel.io_printer       = io_cycle && (bus.a[7:0] == `IO_PRINTER);
    assign sel.io_keyb_scramble = io_cycle && (bus.a[7:0] == `IO_KEYB_SCRAMBLE);

    assign internal = sel.vram | sel.io_bank | sel.io_cassette | sel.io_vsync_cpm
                      | sel.io_printer | sel.io_keyb_scramble;

    //////////////////////////////////////////////////////////////////////
    // External memory
    //////////////////////////////////////////////////////////////////////
    assign ro_write  = !bus.wr_n && active_bank.f.ro;

    // Sysram has its own chip enable path in page 0
    assign allow_mem = mem_cycle && !internal && !sel.sysram && !ro_write;

    assign sel.rom = allow_mem && (active_bank.f.page[5:4] == 2'b00);  // Pages 0-15
    assign sel.ram = allow_mem && active_bank.f.page[5];               // Pages 32-63

    // Only one target per cycle, given a sane bus
    always_comb begin
        if (bus.mreq_n || bus.iorq_n) begin
            a_one_select: assert ($onehot0({sel.vram, sel.sysram, sel.rom, sel.ram,
                                            sel.io_bank, sel.io_cassette,
                                            sel.io_vsync_cpm, sel.io_printer,
                                            sel.io_keyb_scramble}))
                else $error("Multiple selects at address %h", bus.a);
        end
    end

endmodule

`default_nettype wire

//--- src/read_data_mux.sv
`timescale 1ns/1ps
`default_nettype none

module read_data_mux import bus_pkg::*; (
    input  mem_select_t sel,
    input  bank_reg_u   active_bank,
    input  logic        internal,
    input  z80_bus_t    bus,
    input  bank_file_t  banks,
    input  logic [7:0]  vram_data,
    input  logic [63:0] keys,
    input  logic        cassette_in,
    input  logic        printer_in,
    input  logic        vblank,
    output logic [7:0]  d_out,
    output logic        d_oe,
    output logic        rom_ce_n,
    output logic        ram_ce_n,
    output logic [4:0]  ba
);

    logic [7:0] keyb_data;

    //////////////////////////////////////////////////////////////////////
    // Keyboard matrix, rows scanned by address bits 15:8
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        keyb_data = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!bus.a[8 + row])
                keyb_data = keyb_data & keys[row*8 +: 8];   // Low line selects row
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Internal read data
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        d_out = 8'h00;
        if (sel.vram)
            d_out = vram_data;                            // One cycle behind address
        else if (sel.io_bank)
            d_out = banks[sel.io_bank_index].raw;
        else if (sel.io_cassette)
            d_out = {7'b0, cassette_in};
        else if (sel.io_vsync_cpm)
            d_out = {7'b0, !vblank};
        else if (sel.io_printer)
            d_out = {7'b0, printer_in};
        else if (sel.io_keyb_scramble)
            d_out = keyb_data;
    end

    assign d_oe = !bus.rd_n && internal;

    // External chip enables and bank address
    assign rom_ce_n = !sel.rom;
    assign ram_ce_n = !(sel.ram || sel.sysram);
    assign ba       = sel.sysram ? 5'd0 : active_bank.f.page[4:0];   // Sysram lives in page 0

    // Never fight the CPU on the data bus
    always_comb begin
        if (!bus.wr_n) begin
            a_no_drive_on_write: assert (!d_oe)
                else $error("Data driven during write at %h", bus.a);
        end
    end

endmodule

`default_nettype wire

//--- src/video_ram.sv
`timescale 1ns/1ps
`default_nettype none
`include "bus_config.svh"

module video_ram (
    input  logic                       sysclk,
    input  logic [`VRAM_ADDR_BITS-1:0] addr,
    input  logic [7:0]                 wrdata,
    input  logic                       wren,
    output logic [7:0]                 rddata
);

    localparam int DEPTH = 1 << `VRAM_ADDR_BITS;   // 2048 bytes

    logic [7:0] mem [DEPTH];

    //////////////////////////////////////////////////////////////////////
    // Single port, registered read
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge sysclk) begin
        if (wren)
            mem[addr] <= wrdata;
    end

    // Old data on a same-cycle write
    always_ff @(posedge sysclk) begin
        rddata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- verification/bus_golden.txt
# test op addr data | exp: d_out d_oe rom_ce_n ram_ce_n ba | cas prn cpm scramble (hex)
# op: 1 mem rd, 2 mem wr, 3 io rd, 4 io wr, 5 key row (addr=row), 6 status (b0 cas b1 prn b2 vbl)
# 100 in d_out or ba means that column is not compared
1 3 00F0 00 C0 1 1 1 100 0 0 0 00
1 3 00F1 00 21 1 1 1 100 0 0 0 00
1 3 00F2 00 22 1 1 1 100 0 0 0 00
1 3 00F3 00 13 1 1 1 100 0 0 0 00
1 3 00FC 00 00 1 1 1 100 0 0 0 00
2 4 00F1 25 100 0 1 1 100 0 0 0 00
2 3 00F1 00 25 1 1 1 100 0 0 0 00
2 1 4000 00 00 0 1 0 05 0 0 0 00
2 4 00F2 03 100 0 1 1 100 0 0 0 00
2 1 8000 00 00 0 0 1 03 0 0 0 00
3 4 00F3 A1 100 0 1 1 100 0 0 0 00
3 2 C000 55 100 0 1 1 01 0 0 0 00
3 1 C000 00 00 0 1 0 01 0 0 0 00
4 4 00F0 40 100 0 1 1 100 0 0 0 00
4 2 3123 A5 100 0 1 1 00 0 0 0 00
4 2 3456 3C 100 0 1 1 00 0 0 0 00
4 1 3123 00 A5 1 1 1 00 0 0 0 00
4 1 3456 00 3C 1 1 1 00 0 0 0 00
4 1 3800 00 00 0 1 0 00 0 0 0 00
4 1 0000 00 00 0 0 1 00 0 0 0 00
5 5 0000 7E 100 0 1 1 100 0 0 0 00
5 5 0001 DB 100 0 1 1 100 0 0 0 00
5 5 0002 00 100 0 1 1 100 0 0 0 00
5 5 0007 F5 100 0 1 1 100 0 0 0 00
5 3 FEFF 00 7E 1 1 1 100 0 0 0 00
5 3 7CFF 00 50 1 1 1 100 0 0 0 00
5 6 0000 03 100 0 1 1 100 0 0 0 00
5 3 00FC 00 01 1 1 1 100 0 0 0 00
5 3 00FD 00 01 1 1 1 100 0 0 0 00
5 3 00FE 00 01 1 1 1 100 0 0 0 00
5 6 0000 04 100 0 1 1 100 0 0 0 00
5 3 00FC 00 00 1 1 1 100 0 0 0 00
5 3 00FD 00 00 1 1 1 100 0 0 0 00
5 3 00FE 00 00 1 1 1 100 0 0 0 00
6 4 00FC 01 100 0 1 1 100 1 0 0 00
6 4 00FD 03 100 0 1 1 100 1 0 1 00
6 4 00FE FF 100 0 1 1 100 1 1 1 00
6 4 00FF 5A 100 0 1 1 100 1 1 1 5A
6 4 00FC 02 100 0 1 1 100 0 1 1 5A

//--- verification/tb_bus_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bus_controller import bus_pkg::*; ();

    localparam string GOLDEN_FILE = "verification/bus_golden.txt";
    localparam int FIELDS   = 13;
    localparam int NO_CHECK = 'h100;    // Column value that is not compared

    // Golden columns
    localparam int C_TEST = 0;
    localparam int C_OP   = 1;
    localparam int C_ADDR = 2;
    localparam int C_DATA = 3;
    localparam int C_D    = 4;
    localparam int C_OE   = 5;
    localparam int C_ROM  = 6;
    localparam int C_RAM  = 7;
    localparam int C_BA   = 8;
    localparam int C_CAS  = 9;
    localparam int C_PRN  = 10;
    localparam int C_CPM  = 11;
    localparam int C_SCR  = 12;

    localparam int OP_MEM_RD  = 1;
    localparam int OP_MEM_WR  = 2;
    localparam int OP_IO_RD   = 3;
    localparam int OP_IO_WR   = 4;
    localparam int OP_KEY_ROW = 5;
    localparam int OP_STATUS  = 6;

    logic        sysclk;
    logic        reset;
    z80_bus_t    bus;
    logic [63:0] keys;
    logic        cassette_in;
    logic        printer_in;
    logic        vblank;
    logic [7:0]  d_out;
    logic        d_oe;
    logic        rom_ce_n;
    logic        ram_ce_n;
    logic [4:0]  ba;
    logic        cassette_out;
    logic        printer_out;
    logic        cpm_remap;
    logic [7:0]  scramble_value;

    int golden[$];      // FIELDS entries per line
    int num_lines;
    int cur_test;
    int test_errors;
    int tests_run;
    int tests_failed;
    int checks;
    int errors;
    int cycles;
    int cycle_limit;

    tb_clock_gen u_clk (.sysclk(sysclk));

    bus_controller_top uut (
        .sysclk         (sysclk),
        .reset          (reset),
        .bus            (bus),
        .keys           (keys),
        .cassette_in    (cassette_in),
        .printer_in     (printer_in),
        .vblank         (vblank),
        .d_out          (d_out),
        .d_oe           (d_oe),
        .rom_ce_n       (rom_ce_n),
        .ram_ce_n       (ram_ce_n),
        .ba             (ba),
        .cassette_out   (cassette_out),
        .printer_out    (printer_out),
        .cpm_remap      (cpm_remap),
        .scramble_value (scramble_value)
    );

    //////////////////////////////////////////////////////////////////////
    // Golden file access
    //////////////////////////////////////////////////////////////////////
    task automatic load_golden();
        int fd;
        int n;
        int v[FIELDS];
        string line;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h", v[0], v[1],
                            v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                            v[12]);
                if (n == FIELDS) begin    // Comment and blank lines fall through
                    for (int k = 0; k < FIELDS; k++)
                        golden.push_back(v[k]);
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic int col(input int line, input int c);
        return golden[line * FIELDS + c];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string what, input int got, input int expected);
        checks++;
        assert (got == expected)
        else begin
            $display("Mismatch at %0t: test %0d %s is %0h, expected %0h",
                     $time, cur_test, what, got, expected);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_outputs(input int line);
        if (col(line, C_D) != NO_CHECK)
            check_value("d_out", int'(d_out), col(line, C_D));
        check_value("d_oe", int'(d_oe), col(line, C_OE));
        check_value("rom_ce_n", int'(rom_ce_n), col(line, C_ROM));
        check_value("ram_ce_n", int'(ram_ce_n), col(line, C_RAM));
        if (col(line, C_BA) != NO_CHECK)
            check_value("ba", int'(ba), col(line, C_BA));
    endtask

    task automatic check_latches(input int line);
        check_value("cassette_out", int'(cassette_out), col(line, C_CAS));
        check_value("printer_out", int'(printer_out), col(line, C_PRN));
        check_value("cpm_remap", int'(cpm_remap), col(line, C_CPM));
        check_value("scramble_value", int'(scramble_value), col(line, C_SCR));
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus cycles
    //////////////////////////////////////////////////////////////////////
    task automatic release_bus();
        bus.rd_n   <= 1'b1;
        bus.wr_n   <= 1'b1;
        bus.mreq_n <= 1'b1;
        bus.iorq_n <= 1'b1;
    endtask

    task automatic run_line(input int line);
        int op;
        int data;
        op   = col(line, C_OP);
        data = col(line, C_DATA);
        @(posedge sysclk);
        if (op == OP_KEY_ROW) begin
            keys[(col(line, C_ADDR) % 8) * 8 +: 8] <= 8'(data);
            @(negedge sysclk);
            check_latches(line);
        end else if (op == OP_STATUS) begin
            cassette_in <= data[0];
            printer_in  <= data[1];
            vblank      <= data[2];
            @(negedge sysclk);
            check_latches(line);
        end else begin
            bus.a      <= 16'(col(line, C_ADDR));
            bus.d      <= 8'(data);
            bus.mreq_n <= !(op == OP_MEM_RD || op == OP_MEM_WR);
            bus.iorq_n <= !(op == OP_IO_RD || op == OP_IO_WR);
            bus.rd_n   <= !(op == OP_MEM_RD || op == OP_IO_RD);
            bus.wr_n   <= !(op == OP_MEM_WR || op == OP_IO_WR);
            @(posedge sysclk);
            @(negedge sysclk);
            check_outputs(line);
            if (op == OP_MEM_RD || op == OP_IO_RD) begin
                check_latches(line);
                @(posedge sysclk);       // rd_n low for two edges
                release_bus();
            end else begin
                repeat (3) @(posedge sysclk);   // wr_n low for four edges
                release_bus();
                repeat (2) @(posedge sysclk);
                @(negedge sysclk);
                check_latches(line);
            end
        end
    endtask

    task automatic finish_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d done, no errors", cur_test);
        end else begin
            $display("Test %0d done, %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // Run limit
    always @(posedge sysclk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        bus         = '0;
        bus.rd_n    = 1'b1;
        bus.wr_n    = 1'b1;
        bus.mreq_n  = 1'b1;
        bus.iorq_n  = 1'b1;
        keys        = '1;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        vblank      = 1'b0;
        cycles      = 0;
        cycle_limit = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        tests_run   = 0;
        tests_failed = 0;
        load_golden();
        num_lines = golden.size() / FIELDS;
        if (num_lines == 0) begin
            $display("No test lines were read from %s", GOLDEN_FILE);
            $display("sim failed");
            $finish;
        end else begin
            cycle_limit = num_lines * 10 + 50;
            repeat (5) @(posedge sysclk);
            reset <= 1'b0;
            cur_test = col(0, C_TEST);
            for (int i = 0; i < num_lines; i++) begin
                if (col(i, C_TEST) != cur_test) begin
                    finish_test();
                    cur_test = col(i, C_TEST);
                end
                run_line(i);
            end
            finish_test();
            $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                     tests_run, tests_failed, checks, errors);
            if (errors == 0)
                $display("sim passed");
            else
                $display("sim failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic sysclk
);

    localparam time HALF_PERIOD = 50ns;    // 100 ns clock

    initial begin
        sysclk = 1'b0;
    end

    always #(HALF_PERIOD) sysclk = ~sysclk;

endmodule

`default_nettype wire
